// File: rtl/tile_mix_pkg.sv
`default_nettype none

package tile_mix_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pixel and tile widths
	////////////////////////////////////////////////////////////////////////////

	localparam int PRI_W     = 3;
	localparam int COLOR_W   = 8;
	// One dot bit per bit plane
	localparam int DOT_W     = 3;
	localparam int PLANE_PIX = 4;
	// Plane 0 in 3..0, plane 1 in 7..4, plane 2 in 11..8
	localparam int TILE_W    = DOT_W * PLANE_PIX;

	// See-through pixel code
	localparam logic [DOT_W-1:0] DOT_TRANSPARENT = 3'd7;

	////////////////////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] REG_PRI_A = 4'h0;
	localparam logic [ADDR_W-1:0] REG_PRI_B = 4'h4;
	localparam logic [ADDR_W-1:0] REG_CTRL  = 4'h8;

	// Same 32-bit word, read as a priority register or as the control register
	typedef union packed {
		struct packed {
			logic [DATA_W-PRI_W-1:0] rsvd;
			logic [PRI_W-1:0]        level;
		} pri;
		struct packed {
			logic [DATA_W-4:0] rsvd;
			logic              disable_b;
			logic              disable_a;
			logic              flip;
		} ctl;
	} reg_word_u;

endpackage

`default_nettype wire

// File: rtl/pixel_timing.sv
`default_nettype none

// Free-running pixel phase, standing in for the 2H clock of the board.
// Layer A owns the fetch bus in phases 0..1, layer B in phases 2..3.
module pixel_timing (
	input  wire        CLK_6M,
	input  wire        rst,
	output logic [1:0] phase,
	output logic       fetch_layer,
	output logic       capture_a,
	output logic       load_a,
	output logic       capture_b,
	output logic       load_b
);

	localparam logic [1:0] PH_FETCH_A_END = 2'd1;
	localparam logic [1:0] PH_FETCH_B_END = 2'd3;

	logic [1:0] phase_q;

	////////////////////////////////////////////////////////////////////////////
	// Phase counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			phase_q <= 2'd0;
		end else begin
			// Wraps 3 -> 0 on its own
			phase_q <= phase_q + 2'd1;
		end
	end

	assign phase = phase_q;

	// Upper phase bit plays the role of 2H
	assign fetch_layer = phase_q[1];

	////////////////////////////////////////////////////////////////////////////
	// Capture and load strobes
	////////////////////////////////////////////////////////////////////////////

	// Each layer captures on the last cycle of its own fetch half
	assign capture_a = (phase_q == PH_FETCH_A_END);
	assign capture_b = (phase_q == PH_FETCH_B_END);

	// Loads are staggered half a tile slot behind the captures, so the
	// shadow of one layer is stable while the other layer is fetched
	assign load_a = (phase_q == PH_FETCH_B_END);
	assign load_b = (phase_q == PH_FETCH_A_END);

endmodule

`default_nettype wire

// File: rtl/layer_shifter.sv
`default_nettype none

// One tile layer: shadow capture from the fetch bus, then a 4-pixel
// shift of the three bit planes.
module layer_shifter import tile_mix_pkg::*; (
	input  wire                CLK_6M,
	input  wire                rst,
	input  wire                capture,
	input  wire                load,
	input  wire                flip,
	input  wire  [TILE_W-1:0]  tile_data,
	input  wire  [COLOR_W-1:0] tile_attr,
	output logic [DOT_W-1:0]   dot,
	output logic [COLOR_W-1:0] color
);

	logic [PLANE_PIX-1:0] shadow_plane [DOT_W];
	logic [COLOR_W-1:0]   shadow_attr;
	logic [PLANE_PIX-1:0] shift_plane  [DOT_W];

	////////////////////////////////////////////////////////////////////////////
	// Shadow capture
	////////////////////////////////////////////////////////////////////////////

	// Holds one tile slice until the load strobe
	always_ff @(posedge CLK_6M) begin
		if (capture) begin
			for (int p = 0; p < DOT_W; p++) begin
				shadow_plane[p] <= tile_data[p*PLANE_PIX +: PLANE_PIX];
			end
			shadow_attr <= tile_attr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Plane shifters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			for (int p = 0; p < DOT_W; p++) begin
				shift_plane[p] <= '0;
			end
			color <= '0;
		end else if (load) begin
			for (int p = 0; p < DOT_W; p++) begin
				shift_plane[p] <= shadow_plane[p];
			end
			color <= shadow_attr;
		end else if (flip) begin
			// Flipped tiles leave from the LSB end
			for (int p = 0; p < DOT_W; p++) begin
				shift_plane[p] <= shift_plane[p] >> 1;
			end
		end else begin
			for (int p = 0; p < DOT_W; p++) begin
				shift_plane[p] <= shift_plane[p] << 1;
			end
		end
	end

	// Dot bits come from the exit end of each plane.
	// Colour stays put for all four pixels of the slice.
	always_comb begin
		for (int p = 0; p < DOT_W; p++) begin
			if (flip) begin
				dot[p] = shift_plane[p][0];
			end else begin
				dot[p] = shift_plane[p][PLANE_PIX-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mix_regs.sv
`default_nettype none

// APB register file for the layer priorities and the control bits.
// Zero wait states; an unmapped offset errors and writes nothing.
module mix_regs import tile_mix_pkg::*; #(
	parameter logic [PRI_W-1:0] RESET_PRI_A = '0,
	parameter logic [PRI_W-1:0] RESET_PRI_B = '0
) (
	input  wire               CLK_6M,
	input  wire               rst,
	input  wire               psel,
	input  wire               penable,
	input  wire               pwrite,
	input  wire  [ADDR_W-1:0] paddr,
	input  wire  [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output logic              pslverr,
	output logic [PRI_W-1:0]  pri_a,
	output logic [PRI_W-1:0]  pri_b,
	output logic              flip,
	output logic              disable_a,
	output logic              disable_b
);

	logic      access;
	logic      sel_pri_a;
	logic      sel_pri_b;
	logic      sel_ctrl;
	logic      mapped;
	logic      wr_en;
	reg_word_u wr_word;
	reg_word_u rd_word;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	assign access    = psel & penable;
	assign sel_pri_a = (paddr == REG_PRI_A);
	assign sel_pri_b = (paddr == REG_PRI_B);
	assign sel_ctrl  = (paddr == REG_CTRL);
	assign mapped    = sel_pri_a | sel_pri_b | sel_ctrl;

	// No wait states
	assign pready  = access;
	assign pslverr = access & ~mapped;

	assign wr_en   = access & pwrite & mapped;
	assign wr_word = pwdata;

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pri_a     <= RESET_PRI_A;
			pri_b     <= RESET_PRI_B;
			flip      <= 1'b0;
			disable_a <= 1'b0;
			disable_b <= 1'b0;
		end else if (wr_en) begin
			if (sel_pri_a) begin
				pri_a <= wr_word.pri.level;
			end
			if (sel_pri_b) begin
				pri_b <= wr_word.pri.level;
			end
			if (sel_ctrl) begin
				flip      <= wr_word.ctl.flip;
				disable_a <= wr_word.ctl.disable_a;
				disable_b <= wr_word.ctl.disable_b;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read back
	////////////////////////////////////////////////////////////////////////////

	// Reserved bits always read as zero
	always_comb begin
		rd_word = '0;
		if (sel_pri_a) begin
			rd_word.pri.level = pri_a;
		end else if (sel_pri_b) begin
			rd_word.pri.level = pri_b;
		end else if (sel_ctrl) begin
			rd_word.ctl.flip      = flip;
			rd_word.ctl.disable_a = disable_a;
			rd_word.ctl.disable_b = disable_b;
		end
		prdata = rd_word;
	end

endmodule

`default_nettype wire

// File: rtl/layer_mixer.sv
`default_nettype none

// Per-pixel choice between layer A, layer B and the upstream background.
// One register stage to the outputs.
module layer_mixer import tile_mix_pkg::*; (
	input  wire                CLK_6M,
	input  wire                rst,
	input  wire  [DOT_W-1:0]   dot_a,
	input  wire  [COLOR_W-1:0] color_a,
	input  wire  [DOT_W-1:0]   dot_b,
	input  wire  [COLOR_W-1:0] color_b,
	input  wire  [PRI_W-1:0]   pri_a,
	input  wire  [PRI_W-1:0]   pri_b,
	input  wire                disable_a,
	input  wire                disable_b,
	input  wire  [PRI_W-1:0]   in_pri,
	input  wire  [COLOR_W-1:0] in_color,
	input  wire  [DOT_W-1:0]   in_dot,
	output logic [PRI_W-1:0]   out_pri,
	output logic [COLOR_W-1:0] out_color,
	output logic [DOT_W-1:0]   out_dot
);

	logic qual_a;
	logic qual_b;
	logic pick_a;
	logic pick_b;

	////////////////////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////////////////////

	// A layer must be opaque, enabled and strictly above the background
	assign qual_a = (dot_a != DOT_TRANSPARENT) && !disable_a && (pri_a > in_pri);
	assign qual_b = (dot_b != DOT_TRANSPARENT) && !disable_b && (pri_b > in_pri);

	// Tie goes to layer A
	assign pick_b = qual_b && (!qual_a || (pri_b > pri_a));
	assign pick_a = qual_a && !pick_b;

	////////////////////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			out_pri   <= '0;
			out_color <= '0;
			out_dot   <= '0;
		end else if (pick_b) begin
			out_pri   <= pri_b;
			out_color <= color_b;
			out_dot   <= dot_b;
		end else if (pick_a) begin
			out_pri   <= pri_a;
			out_color <= color_a;
			out_dot   <= dot_a;
		end else begin
			// Background pixel passes down the chain
			out_pri   <= in_pri;
			out_color <= in_color;
			out_dot   <= in_dot;
		end
	end

endmodule

`default_nettype wire

// File: rtl/tile_mixer_top.sv
`default_nettype none

module tile_mixer_top import tile_mix_pkg::*; #(
	parameter logic [PRI_W-1:0] RESET_PRI_A = '0,
	parameter logic [PRI_W-1:0] RESET_PRI_B = '0
) (
	input  wire                CLK_6M,
	input  wire                rst,
	// APB
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire  [ADDR_W-1:0]  paddr,
	input  wire  [DATA_W-1:0]  pwdata,
	output wire  [DATA_W-1:0]  prdata,
	output wire                pready,
	output wire                pslverr,
	// Tile fetch bus
	output wire                fetch_layer,
	input  wire  [TILE_W-1:0]  tile_data,
	input  wire  [COLOR_W-1:0] tile_attr,
	output wire  [1:0]         pixel_phase,
	// Background chain
	input  wire  [PRI_W-1:0]   in_pri,
	input  wire  [COLOR_W-1:0] in_color,
	input  wire  [DOT_W-1:0]   in_dot,
	output wire  [PRI_W-1:0]   out_pri,
	output wire  [COLOR_W-1:0] out_color,
	output wire  [DOT_W-1:0]   out_dot
);

	wire               capture_a;
	wire               load_a;
	wire               capture_b;
	wire               load_b;
	wire [DOT_W-1:0]   dot_a;
	wire [COLOR_W-1:0] color_a;
	wire [DOT_W-1:0]   dot_b;
	wire [COLOR_W-1:0] color_b;
	wire [PRI_W-1:0]   pri_a;
	wire [PRI_W-1:0]   pri_b;
	wire               flip;
	wire               disable_a;
	wire               disable_b;

	pixel_timing timing0 (
		.CLK_6M(CLK_6M), .rst(rst), .phase(pixel_phase), .fetch_layer(fetch_layer),
		.capture_a(capture_a), .load_a(load_a), .capture_b(capture_b), .load_b(load_b)
	);

	// Both layers watch the same bus, each captures in its own half
	layer_shifter layer_a (
		.CLK_6M(CLK_6M), .rst(rst), .capture(capture_a), .load(load_a), .flip(flip),
		.tile_data(tile_data), .tile_attr(tile_attr), .dot(dot_a), .color(color_a)
	);

	layer_shifter layer_b (
		.CLK_6M(CLK_6M), .rst(rst), .capture(capture_b), .load(load_b), .flip(flip),
		.tile_data(tile_data), .tile_attr(tile_attr), .dot(dot_b), .color(color_b)
	);

	mix_regs #(
		.RESET_PRI_A(RESET_PRI_A),
		.RESET_PRI_B(RESET_PRI_B)
	) regs0 (
		.CLK_6M(CLK_6M), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .pri_a(pri_a), .pri_b(pri_b), .flip(flip),
		.disable_a(disable_a), .disable_b(disable_b)
	);

	layer_mixer mixer0 (
		.CLK_6M(CLK_6M), .rst(rst),
		.dot_a(dot_a), .color_a(color_a), .dot_b(dot_b), .color_b(color_b),
		.pri_a(pri_a), .pri_b(pri_b), .disable_a(disable_a), .disable_b(disable_b),
		.in_pri(in_pri), .in_color(in_color), .in_dot(in_dot),
		.out_pri(out_pri), .out_color(out_color), .out_dot(out_dot)
	);

endmodule

`default_nettype wire

// File: verif/tile_mixer_tb.sv
`default_nettype none

module tile_mixer_tb import tile_mix_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [PRI_W-1:0] RST_PRI_A  = 3'd5;
	localparam logic [PRI_W-1:0] RST_PRI_B  = 3'd2;
	localparam int               NUM_ROWS   = 12;
	localparam int               ROW_W      = 55;
	localparam int               WAIT_LIMIT = 50;

	logic               CLK_6M;
	logic               rst;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [ADDR_W-1:0]  paddr;
	logic [DATA_W-1:0]  pwdata;
	logic [TILE_W-1:0]  tile_data;
	logic [COLOR_W-1:0] tile_attr;
	logic [PRI_W-1:0]   in_pri;
	logic [COLOR_W-1:0] in_color;
	logic [DOT_W-1:0]   in_dot;

	wire  [DATA_W-1:0]  prdata;
	wire                pready;
	wire                pslverr;
	wire                fetch_layer;
	wire  [1:0]         pixel_phase;
	wire  [PRI_W-1:0]   out_pri;
	wire  [COLOR_W-1:0] out_color;
	wire  [DOT_W-1:0]   out_dot;

	// Row layout, MSB first: pri_a, pri_b, ctl {disable_b, disable_a, flip},
	// A data, A attr, B data, B attr, in_pri, in_dot
	logic [ROW_W-1:0]   table_rows [NUM_ROWS];
	logic [TILE_W-1:0]  cur_a_data;
	logic [COLOR_W-1:0] cur_a_attr;
	logic [TILE_W-1:0]  cur_b_data;
	logic [COLOR_W-1:0] cur_b_attr;
	logic [1:0]         next_phase;
	int                 value_errors;
	int                 timeout_errors;
	int                 seed_value;

	tile_mixer_top #(
		.RESET_PRI_A(RST_PRI_A),
		.RESET_PRI_B(RST_PRI_B)
	) dut0 (
		.CLK_6M(CLK_6M), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .fetch_layer(fetch_layer), .tile_data(tile_data),
		.tile_attr(tile_attr), .pixel_phase(pixel_phase), .in_pri(in_pri),
		.in_color(in_color), .in_dot(in_dot), .out_pri(out_pri),
		.out_color(out_color), .out_dot(out_dot)
	);

	initial CLK_6M = 1'b0;
	always #5 CLK_6M = ~CLK_6M;

	// Bus carries the layer that owns the coming cycle, like the tile RAM
	always @(posedge CLK_6M) begin
		next_phase = pixel_phase + 2'd1;
		if (next_phase[1]) begin
			tile_data <= cur_b_data;
			tile_attr <= cur_b_attr;
		end else begin
			tile_data <= cur_a_data;
			tile_attr <= cur_a_attr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Unflipped pixel i is bit 3-i of each plane, flipped it is bit i
	function automatic logic [DOT_W-1:0] slice_dot(input logic [TILE_W-1:0] data,
		input int idx, input logic flip);
		int              bit_pos;
		logic [DOT_W-1:0] d;
		bit_pos = flip ? idx : (PLANE_PIX - 1 - idx);
		for (int pl = 0; pl < DOT_W; pl++) begin
			d[pl] = data[pl*PLANE_PIX + bit_pos];
		end
		return d;
	endfunction

	// Returns {pri, color, dot} expected on out_* during the given phase
	function automatic logic [13:0] expected_pixel(input logic [ROW_W-1:0] row,
		input logic [COLOR_W-1:0] bg_color, input logic [1:0] phase);
		logic [2:0] pa;
		logic [2:0] pb;
		logic [2:0] ctl;
		logic [2:0] da;
		logic [2:0] db;
		logic       qa;
		logic       qb;
		pa  = row[54:52];
		pb  = row[51:49];
		ctl = row[48:46];
		da  = slice_dot(row[45:34], (int'(phase) + 3) % 4, ctl[0]);
		db  = slice_dot(row[25:14], (int'(phase) + 1) % 4, ctl[0]);
		qa  = (da != DOT_TRANSPARENT) && !ctl[1] && (pa > row[5:3]);
		qb  = (db != DOT_TRANSPARENT) && !ctl[2] && (pb > row[5:3]);
		// Layer A wins ties among qualifying layers
		if (qa && (!qb || pa >= pb)) begin
			return {pa, row[33:26], da};
		end else if (qb) begin
			return {pb, row[13:6], db};
		end
		return {row[5:3], bg_color, row[2:0]};
	endfunction

	function automatic logic [ROW_W-1:0] make_row(input logic [2:0] pa, input logic [2:0] pb,
		input logic [2:0] ctl, input logic [11:0] ad, input logic [7:0] aa,
		input logic [11:0] bd, input logic [7:0] ba, input logic [2:0] ipri,
		input logic [2:0] idot);
		return {pa, pb, ctl, ad, aa, bd, ba, ipri, idot};
	endfunction

	task automatic fill_table();
		// Opaque layers, priority order and ties
		table_rows[0]  = make_row(3'd4, 3'd3, 3'b000, 12'h0C5, 8'h11, 12'h3A0, 8'h22, 3'd0, 3'd0);
		table_rows[1]  = make_row(3'd2, 3'd6, 3'b000, 12'h0C5, 8'h31, 12'h3A0, 8'h42, 3'd0, 3'd0);
		table_rows[2]  = make_row(3'd5, 3'd5, 3'b000, 12'h0C5, 8'h53, 12'h3A0, 8'h64, 3'd1, 3'd0);
		// Flipped slices
		table_rows[3]  = make_row(3'd3, 3'd6, 3'b001, 12'h0C5, 8'h75, 12'h3A0, 8'h86, 3'd0, 3'd0);
		table_rows[4]  = make_row(3'd7, 3'd1, 3'b001, 12'h0C5, 8'h97, 12'h3A0, 8'hA8, 3'd0, 3'd0);
		// Transparency and disables
		table_rows[5]  = make_row(3'd6, 3'd2, 3'b000, 12'hE6F, 8'hB9, 12'h3A0, 8'hCA, 3'd0, 3'd0);
		table_rows[6]  = make_row(3'd6, 3'd7, 3'b000, 12'hE6F, 8'hDB, 12'hFFF, 8'hEC, 3'd1, 3'd2);
		table_rows[7]  = make_row(3'd7, 3'd3, 3'b010, 12'h0C5, 8'hFD, 12'h3A0, 8'h0E, 3'd0, 3'd0);
		table_rows[8]  = make_row(3'd4, 3'd5, 3'b110, 12'h0C5, 8'h1F, 12'h3A0, 8'h20, 3'd2, 3'd5);
		// Background priority at or above a layer
		table_rows[9]  = make_row(3'd3, 3'd5, 3'b000, 12'h0C5, 8'h41, 12'hE6F, 8'h52, 3'd3, 3'd1);
		table_rows[10] = make_row(3'd4, 3'd4, 3'b000, 12'h0C5, 8'h63, 12'h3A0, 8'h74, 3'd4, 3'd3);
		table_rows[11] = make_row(3'd5, 3'd6, 3'b101, 12'hE6F, 8'h85, 12'h3A0, 8'h96, 3'd2, 3'd6);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic wait_ready(output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge CLK_6M);
			if (pready === 1'b1) begin
				ok = 1'b1;
			end
			cycles++;
		end
		if (!ok) begin
			$display("Timeout at %0t: APB access never saw pready", $time);
			timeout_errors++;
		end
	endtask

	task automatic wait_phase(input logic [1:0] target);
		int cycles;
		cycles = 0;
		@(negedge CLK_6M);
		while (pixel_phase !== target && cycles < WAIT_LIMIT) begin
			@(negedge CLK_6M);
			cycles++;
		end
		if (pixel_phase !== target) begin
			$display("Timeout at %0t: pixel phase never reached %0d", $time, target);
			timeout_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_access(input logic write, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic err);
		logic ok;
		@(posedge CLK_6M);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge CLK_6M);
		penable <= 1'b1;
		wait_ready(ok);
		rdata = prdata;
		err   = pslverr;
		// Access completes at this edge
		@(posedge CLK_6M);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rdata;
		logic              err;
		apb_access(1'b1, addr, data, rdata, err);
		check_eq(err, 1'b0, $sformatf("pslverr on write to %0h", addr));
	endtask

	task automatic apb_read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] rdata;
		logic              err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_eq(err, 1'b0, $sformatf("pslverr on read of %0h", addr));
		check_eq(rdata, exp, $sformatf("read of %0h", addr));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [DATA_W-1:0]  rdata;
		logic               err;
		logic [13:0]        exp_pix;
		logic [ROW_W-1:0]   row;
		logic [COLOR_W-1:0] bg_color;
		logic [1:0]         exp_phase;
		value_errors   = 0;
		timeout_errors = 0;
		seed_value     = $urandom(32'h9569fe6d);
		rst        = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		tile_data  = '0;
		tile_attr  = '0;
		in_pri     = '0;
		in_color   = '0;
		in_dot     = '0;
		cur_a_data = '0;
		cur_a_attr = '0;
		cur_b_data = '0;
		cur_b_attr = '0;
		fill_table();

		repeat (16) @(posedge CLK_6M);
		rst <= 1'b0;
		@(negedge CLK_6M);
		check_eq(out_pri, 0, "out_pri after reset");
		check_eq(out_color, 0, "out_color after reset");
		check_eq(out_dot, 0, "out_dot after reset");
		check_eq(pready, 1'b0, "pready after reset");
		check_eq(pslverr, 1'b0, "pslverr after reset");
		check_eq(pixel_phase, 0, "pixel_phase after reset");
		apb_read_check(REG_PRI_A, RST_PRI_A);
		apb_read_check(REG_PRI_B, RST_PRI_B);
		apb_read_check(REG_CTRL, 32'h0);

		// Reserved bits are dropped on write
		apb_write(REG_PRI_A, 32'hFFFF_FFF6);
		apb_read_check(REG_PRI_A, 32'h6);
		apb_write(REG_PRI_B, 32'h8000_0001);
		apb_read_check(REG_PRI_B, 32'h1);
		apb_write(REG_CTRL, 32'hFFFF_FFF9);
		apb_read_check(REG_CTRL, 32'h1);

		// Offset 0xC is unmapped
		apb_access(1'b1, 4'hC, 32'hFFFF_FFFF, rdata, err);
		check_eq(err, 1'b1, "pslverr on write to C");
		apb_access(1'b0, 4'hC, '0, rdata, err);
		check_eq(err, 1'b1, "pslverr on read of C");
		apb_read_check(REG_PRI_A, 32'h6);
		apb_read_check(REG_PRI_B, 32'h1);
		apb_read_check(REG_CTRL, 32'h1);

		for (int r = 0; r < NUM_ROWS; r++) begin
			row = table_rows[r];
			apb_write(REG_PRI_A, {29'd0, row[54:52]});
			apb_write(REG_PRI_B, {29'd0, row[51:49]});
			apb_write(REG_CTRL, {29'd0, row[48:46]});
			bg_color = 8'($urandom());
			@(posedge CLK_6M);
			cur_a_data <= row[45:34];
			cur_a_attr <= row[33:26];
			cur_b_data <= row[25:14];
			cur_b_attr <= row[13:6];
			in_pri     <= row[5:3];
			in_color   <= bg_color;
			in_dot     <= row[2:0];
			// Shadow, shifters and mixer all refill well within this
			repeat (12) @(posedge CLK_6M);
			wait_phase(2'd0);
			for (int c = 0; c < 8; c++) begin
				if (c > 0) begin
					@(negedge CLK_6M);
				end
				// Phase steps once per clock from the aligned zero
				exp_phase = 2'(c);
				check_eq(pixel_phase, exp_phase,
					$sformatf("row %0d cycle %0d pixel_phase", r, c));
				check_eq(fetch_layer, exp_phase >= 2'd2,
					$sformatf("row %0d cycle %0d fetch_layer", r, c));
				exp_pix = expected_pixel(row, bg_color, pixel_phase);
				check_eq(out_pri, exp_pix[13:11], $sformatf("row %0d cycle %0d out_pri", r, c));
				check_eq(out_color, exp_pix[10:3], $sformatf("row %0d cycle %0d out_color", r, c));
				check_eq(out_dot, exp_pix[2:0], $sformatf("row %0d cycle %0d out_dot", r, c));
			end
		end

		$display("Errors: %0d check failures, %0d timeouts", value_errors, timeout_errors);
		if (value_errors + timeout_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tile_mixer_top.f
rtl/tile_mix_pkg.sv
rtl/pixel_timing.sv
rtl/layer_shifter.sv
rtl/mix_regs.sv
rtl/layer_mixer.sv
rtl/tile_mixer_top.sv
verif/tile_mixer_tb.sv
